// File: Makefile
# Verilator flow for the attention coefficient stage

TB_TOP  = tb_gat_attn
RTL_TOP = gat_attn_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(RTL_TOP) -f compile.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TB_TOP) -f compile.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: attn_coef_unit.sv
// ===============================================
// pipelined attention coefficient unit
// coef = ReLU((a_src.Wh_src + a_nbr.Wh_j) >>> shift)
// takes one entry per cycle, writes the coefficient
// COEF_LATENCY cycles after its fetch strobe
// ===============================================

module attn_coef_unit (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 fetch_vld_i,
  input  logic [gat_pkg::WH_WIDTH-1:0]                         fetch_data_i,
  input  logic [gat_pkg::A_DEPTH-1:0][gat_pkg::DATA_WIDTH-1:0] a_i,
  output logic                                                 coef_wr_o,
  output logic [gat_pkg::DATA_WIDTH-1:0]                       coef_o
);

  import gat_pkg::*;

  // weight halves
  logic signed [DATA_WIDTH-1:0]      a_src [HALF_A_SIZE];
  logic signed [DATA_WIDTH-1:0]      a_nbr [HALF_A_SIZE];

  // stage 0 entry register
  logic signed [WH_DATA_WIDTH-1:0]   feat_q [HALF_A_SIZE];

  // products at the leaves, partial sums above, root last
  logic signed [DMVM_DATA_WIDTH-1:0] tree_q [TREE_NODES];

  // valid and source flag travel beside the data
  logic [NUM_STAGES:0]               vld_q;
  logic [NUM_STAGES:0]               src_q;

  // tail
  logic signed [DMVM_DATA_WIDTH-1:0] root_sum;
  logic signed [DMVM_DATA_WIDTH-1:0] src_sum;
  logic signed [DMVM_DATA_WIDTH-1:0] src_hold_q;
  logic signed [DMVM_DATA_WIDTH-1:0] total_sum;
  logic signed [DMVM_DATA_WIDTH-1:0] scaled_sum;
  logic [DATA_WIDTH-1:0]             coef_raw;
  logic [DATA_WIDTH-1:0]             coef_q;
  logic                              coef_wr_q;

  // ===============================================
  // split attention vector
  // ===============================================
  always_comb begin
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      a_src[k] = a_i[k];
      a_nbr[k] = a_i[k + HALF_A_SIZE];
    end
  end

  // ===============================================
  // stage 0, register the entry
  // ===============================================
  // element 0 sits in the top byte
  always_ff @(posedge clk) begin
    if (fetch_vld_i) begin
      for (int k = 0; k < HALF_A_SIZE; k++) begin
        feat_q[k] <= fetch_data_i[WH_WIDTH-1-k*WH_DATA_WIDTH -: WH_DATA_WIDTH];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
      src_q <= '0;
    end else begin
      vld_q <= {vld_q[NUM_STAGES-1:0], fetch_vld_i};
      src_q <= {src_q[NUM_STAGES-1:0], fetch_vld_i & fetch_data_i[0]};
    end
  end

  // ===============================================
  // multiply and adder tree
  // ===============================================
  always_ff @(posedge clk) begin
    // source entries use a_src, neighbours use a_nbr
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      if (src_q[0]) begin
        tree_q[k] <= a_src[k] * feat_q[k];
      end else begin
        tree_q[k] <= a_nbr[k] * feat_q[k];
      end
    end
    // each level halves the number of terms
    for (int s = 1; s < NUM_STAGES; s++) begin
      for (int k = 0; k < (HALF_A_SIZE >> s); k++) begin
        tree_q[tree_offset(s) + k] <= tree_q[tree_offset(s - 1) + 2 * k]
                                    + tree_q[tree_offset(s - 1) + 2 * k + 1];
      end
    end
  end

  // ===============================================
  // source latch, scale and ReLU
  // ===============================================
  assign root_sum = tree_q[TREE_NODES-1];

  // a flagged entry pairs with its own sum
  assign src_sum    = src_q[NUM_STAGES] ? root_sum : src_hold_q;
  assign total_sum  = src_sum + root_sum;
  assign scaled_sum = total_sum >>> COEF_SHIFT;
  assign coef_raw   = scaled_sum[DATA_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold_q <= '0;
      coef_wr_q  <= 1'b0;
    end else begin
      coef_wr_q <= vld_q[NUM_STAGES];
      if (vld_q[NUM_STAGES] && src_q[NUM_STAGES]) begin
        src_hold_q <= root_sum;
      end
    end
  end

  // negative byte clamps to zero
  always_ff @(posedge clk) begin
    if (vld_q[NUM_STAGES]) begin
      coef_q <= coef_raw[DATA_WIDTH-1] ? '0 : coef_raw;
    end
  end

  assign coef_wr_o = coef_wr_q;
  assign coef_o    = coef_q;

endmodule

// File: attn_weight_regs.sv
// ===============================================
// host configuration registers for the attention
// weight vector and the node count; written by
// single-cycle strobes, read out continuously
// ===============================================

module attn_weight_regs (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 cfg_wr_i,
  input  logic [gat_pkg::CFG_ADDR_WIDTH-1:0]                   cfg_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]                       cfg_wdata_i,
  output logic [gat_pkg::A_DEPTH-1:0][gat_pkg::DATA_WIDTH-1:0] a_o,
  output logic [gat_pkg::NUM_NODE_WIDTH-1:0]                   num_node_o
);

  import gat_pkg::*;

  logic [A_DEPTH-1:0][DATA_WIDTH-1:0] a_q;
  logic [NUM_NODE_WIDTH-1:0]          num_node_q;
  logic                               wr_weight;
  logic                               wr_node;

  // ===============================================
  // address decode
  // ===============================================
  // 0..7 source half, 8..15 neighbour half
  assign wr_weight = cfg_wr_i && (cfg_addr_i < CFG_ADDR_WIDTH'(CFG_NODE_ADDR));
  assign wr_node   = cfg_wr_i && (cfg_addr_i == CFG_ADDR_WIDTH'(CFG_NODE_ADDR));

  // ===============================================
  // register file
  // ===============================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q        <= '0;
      num_node_q <= '0;
    end else begin
      if (wr_weight) begin
        a_q[cfg_addr_i[CFG_A_IDX_WIDTH-1:0]] <= cfg_wdata_i;
      end
      // node count comes from the low data bits
      if (wr_node) begin
        num_node_q <= cfg_wdata_i[NUM_NODE_WIDTH-1:0];
      end
    end
  end

  assign a_o        = a_q;
  assign num_node_o = num_node_q;

endmodule

// File: coef_fifo.sv
// ===============================================
// first-word-fall-through coefficient FIFO
// head is always visible, a write into a full FIFO
// is dropped and sets a sticky overflow flag
// ===============================================

module coef_fifo #(
  parameter int DEPTH = gat_pkg::COEF_FIFO_DEPTH
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic                           rd_i,
  output logic [gat_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                           empty_o,
  output logic                           overflow_o
);

  import gat_pkg::*;

  logic [DATA_WIDTH-1:0]        mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         overflow_q;
  logic                         full;
  logic                         do_wr;
  logic                         do_rd;

  assign full    = (count_q == ($clog2(DEPTH+1))'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_wr   = wr_i && !full;
  assign do_rd   = rd_i && !empty_o;

  // ===============================================
  // pointers, count and overflow
  // ===============================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // stays set until reset
      if (wr_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o    = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// File: compile.f
gat_pkg.sv
attn_weight_regs.sv
wh_buffer.sv
attn_coef_unit.sv
coef_fifo.sv
gat_attn_top.sv
tb_gat_attn.sv

// File: gat_attn_top.sv
// ===============================================
// attention coefficient stage of the GAT
// accelerator; host loads weights, node count and
// WH entries, pulses start, then drains the FIFO
// ===============================================

module gat_attn_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_wr_i,
  input  logic [gat_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]    cfg_wdata_i,
  input  logic                              wh_wr_i,
  input  logic [gat_pkg::WH_ADDR_WIDTH-1:0] wh_addr_i,
  input  logic [gat_pkg::WH_WIDTH-1:0]      wh_wdata_i,
  input  logic                              start_i,
  output logic                              busy_o,
  input  logic                              coef_rd_i,
  output logic [gat_pkg::DATA_WIDTH-1:0]    coef_head_o,
  output logic                              coef_empty_o,
  output logic                              overflow_o
);

  import gat_pkg::*;

  logic [A_DEPTH-1:0][DATA_WIDTH-1:0] a_vec;
  logic [NUM_NODE_WIDTH-1:0]          num_node;
  logic                               fetch_vld;
  logic [WH_WIDTH-1:0]                fetch_data;
  logic                               coef_wr;
  logic [DATA_WIDTH-1:0]              coef;

  attn_weight_regs u_weight_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr_i   (cfg_wr_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .a_o        (a_vec),
    .num_node_o (num_node)
  );

  wh_buffer u_wh_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_wr_i     (wh_wr_i),
    .wh_addr_i   (wh_addr_i),
    .wh_wdata_i  (wh_wdata_i),
    .start_i     (start_i),
    .num_node_i  (num_node),
    .fetch_vld_o (fetch_vld),
    .fetch_data_o(fetch_data),
    .busy_o      (busy_o)
  );

  attn_coef_unit u_coef_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_vld_i (fetch_vld),
    .fetch_data_i(fetch_data),
    .a_i         (a_vec),
    .coef_wr_o   (coef_wr),
    .coef_o      (coef)
  );

  coef_fifo #(
    .DEPTH(COEF_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (coef_wr),
    .wdata_i   (coef),
    .rd_i      (coef_rd_i),
    .rdata_o   (coef_head_o),
    .empty_o   (coef_empty_o),
    .overflow_o(overflow_o)
  );

endmodule

// File: gat_pkg.sv
// ===============================================
// shared widths, depths, pipeline lengths and the
// configuration address map for the attention
// coefficient stage, imported by every block
// ===============================================

package gat_pkg;

  // data widths
  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 8;
  localparam int DMVM_DATA_WIDTH = 20;

  // attention vector, split into source and neighbour halves
  localparam int HALF_A_SIZE     = 8;
  localparam int A_DEPTH         = 2 * HALF_A_SIZE;
  localparam int CFG_A_IDX_WIDTH = $clog2(A_DEPTH);

  // features on top, source flag in bit 0
  localparam int WH_WIDTH        = HALF_A_SIZE * WH_DATA_WIDTH + 1;
  localparam int WH_DEPTH        = 32;
  localparam int WH_ADDR_WIDTH   = $clog2(WH_DEPTH);
  localparam int NUM_NODE_WIDTH  = $clog2(WH_DEPTH + 1);

  // pipeline shape
  localparam int COEF_SHIFT      = 12;
  localparam int NUM_STAGES      = $clog2(HALF_A_SIZE) + 1;
  localparam int COEF_LATENCY    = NUM_STAGES + 2;
  localparam int DRAIN_CNT_WIDTH = $clog2(COEF_LATENCY + 1);
  localparam int TREE_NODES      = 2 * HALF_A_SIZE - 1;

  // configuration address map
  localparam int CFG_ADDR_WIDTH  = 5;
  localparam int CFG_NODE_ADDR   = 16;

  localparam int COEF_FIFO_DEPTH = 16;

  // first node of a given adder tree level in the flat tree array
  function automatic int tree_offset(input int stage);
    return 2 * HALF_A_SIZE - ((2 * HALF_A_SIZE) >> stage);
  endfunction

endpackage

// File: tb_gat_attn.sv
// ==================================================
// testbench for the attention coefficient stage
// loads random weights and WH entries, runs the
// fetch sequencer, drains the FIFO and compares
// every coefficient with a model queue
// ==================================================

module tb_gat_attn;

  import gat_pkg::*;

  localparam int unsigned SEED = 32'h208efa99;
  localparam int RAND_RUNS     = 3;
  localparam int MAX_ENTRIES   = RAND_RUNS * 16 + 12 + 12 + 10 + 24;
  localparam int TIMEOUT_CYC   = MAX_ENTRIES * 20 + 2000;
  localparam int IDLE_LIMIT    = WH_DEPTH + COEF_LATENCY + 20;

  logic                                clk;
  logic                                rst_n;
  logic                                cfg_wr_i;
  logic [CFG_ADDR_WIDTH-1:0]           cfg_addr_i;
  logic [DATA_WIDTH-1:0]               cfg_wdata_i;
  logic                                wh_wr_i;
  logic [WH_ADDR_WIDTH-1:0]            wh_addr_i;
  logic [WH_WIDTH-1:0]                 wh_wdata_i;
  logic                                start_i;
  logic                                busy_o;
  logic                                coef_rd_i;
  logic [DATA_WIDTH-1:0]               coef_head_o;
  logic                                coef_empty_o;
  logic                                overflow_o;

  // stimulus tables and model state
  byte        a_tb [A_DEPTH];
  byte        feat_tb [WH_DEPTH][HALF_A_SIZE];
  bit         flag_tb [WH_DEPTH];
  logic [7:0] exp_q [$];
  int         src_model;
  int         test_errs;
  int         pass_cnt;
  int         fail_cnt;

  gat_attn_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr_i    (cfg_wr_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .wh_wr_i     (wh_wr_i),
    .wh_addr_i   (wh_addr_i),
    .wh_wdata_i  (wh_wdata_i),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .coef_rd_i   (coef_rd_i),
    .coef_head_o (coef_head_o),
    .coef_empty_o(coef_empty_o),
    .overflow_o  (overflow_o)
  );

  always #50 clk = ~clk;

  // ==================================================
  // stimulus helpers
  // ==================================================
  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom() % (hi - lo + 1));
  endfunction

  // element 0 in the top byte, source flag in bit 0
  function automatic logic [WH_WIDTH-1:0] pack_entry(input int idx);
    logic [WH_WIDTH-1:0] data;
    data = '0;
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      data[WH_WIDTH-1-k*WH_DATA_WIDTH -: WH_DATA_WIDTH] = feat_tb[idx][k];
    end
    data[0] = flag_tb[idx];
    return data;
  endfunction

  task automatic write_cfg(input int addr, input byte data);
    @(negedge clk);
    cfg_wr_i    = 1'b1;
    cfg_addr_i  = CFG_ADDR_WIDTH'(addr);
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_wr_i    = 1'b0;
  endtask

  task automatic write_entry(input int idx);
    @(negedge clk);
    wh_wr_i    = 1'b1;
    wh_addr_i  = WH_ADDR_WIDTH'(idx);
    wh_wdata_i = pack_entry(idx);
    @(negedge clk);
    wh_wr_i    = 1'b0;
  endtask

  task automatic random_entries(input int n);
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < HALF_A_SIZE; k++) begin
        feat_tb[i][k] = byte'($urandom());
      end
      flag_tb[i] = (i == 0);
    end
  endtask

  // ==================================================
  // reference model
  // ==================================================
  function automatic logic [7:0] relu_byte(input int total);
    int         shifted;
    logic [7:0] low;
    shifted = total >>> COEF_SHIFT;
    low     = shifted[7:0];
    return low[7] ? 8'h00 : low;
  endfunction

  // FIFO starts empty, so anything past its depth is lost
  task automatic model_run(input int n);
    int own;
    for (int i = 0; i < n; i++) begin
      own = 0;
      for (int k = 0; k < HALF_A_SIZE; k++) begin
        if (flag_tb[i]) begin
          own += int'(a_tb[k]) * int'(feat_tb[i][k]);
        end else begin
          own += int'(a_tb[k + HALF_A_SIZE]) * int'(feat_tb[i][k]);
        end
      end
      if (flag_tb[i]) begin
        src_model = own;
      end
      if (exp_q.size() < COEF_FIFO_DEPTH) begin
        exp_q.push_back(relu_byte(src_model + own));
      end
    end
  endtask

  // weights, node count, entries, then the model
  task automatic load_run(input int n);
    for (int k = 0; k < A_DEPTH; k++) begin
      write_cfg(k, a_tb[k]);
    end
    write_cfg(CFG_NODE_ADDR, byte'(n));
    for (int i = 0; i < n; i++) begin
      write_entry(i);
    end
    model_run(n);
  endtask

  // ==================================================
  // run control and checks
  // ==================================================
  task automatic pulse_start();
    @(negedge clk);
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o === 1'b1 && cycles < IDLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (busy_o === 1'b0) else begin
      $display("busy_o still high %0d cycles after start", IDLE_LIMIT);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERROR %s expected %h got %h", name, exp, got);
      test_errs++;
    end
  endtask

  task automatic run_nodes();
    pulse_start();
    check_bit("busy_o", busy_o, 1'b1);
    wait_idle();
  endtask

  // pop one value per cycle and compare with the model queue
  task automatic drain_check();
    int         got_cnt;
    int         exp_cnt;
    logic [7:0] exp;
    exp_cnt = exp_q.size();
    got_cnt = 0;
    @(negedge clk);
    while (coef_empty_o === 1'b0 && got_cnt <= COEF_FIFO_DEPTH) begin
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        assert (coef_head_o === exp) else begin
          $display("ERROR coef_head_o expected %h got %h", exp, coef_head_o);
          test_errs++;
        end
      end
      coef_rd_i = 1'b1;
      got_cnt++;
      @(negedge clk);
    end
    coef_rd_i = 1'b0;
    assert (got_cnt == exp_cnt) else begin
      $display("ERROR coef count expected %0h got %0h", exp_cnt, got_cnt);
      test_errs++;
    end
    exp_q.delete();
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %-14s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-14s failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // ==================================================
  // watchdog
  // ==================================================
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", TIMEOUT_CYC);
    $display("TB FAILED");
    $finish;
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    int n;
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    cfg_wr_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    wh_wr_i     = 1'b0;
    wh_addr_i   = '0;
    wh_wdata_i  = '0;
    start_i     = 1'b0;
    coef_rd_i   = 1'b0;
    src_model   = 0;
    test_errs   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check_bit("coef_empty_o", coef_empty_o, 1'b1);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("overflow_o", overflow_o, 1'b0);
    end_test("reset");

    for (int r = 0; r < RAND_RUNS; r++) begin
      n = rand_range(8, 16);
      for (int k = 0; k < A_DEPTH; k++) begin
        a_tb[k] = byte'($urandom());
      end
      random_entries(n);
      load_run(n);
      run_nodes();
      drain_check();
    end
    end_test("random");

    // negative neighbour weights, even entries go negative
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      a_tb[k]               = 8'sd20;
      a_tb[k + HALF_A_SIZE] = byte'(-rand_range(80, 120));
    end
    for (int i = 0; i < 12; i++) begin
      for (int k = 0; k < HALF_A_SIZE; k++) begin
        feat_tb[i][k] = (i % 2 == 0) ? byte'(rand_range(60, 127)) : byte'(-rand_range(60, 127));
      end
      flag_tb[i] = (i == 0);
    end
    load_run(12);
    run_nodes();
    drain_check();
    end_test("relu_clamp");

    // second source flips the sign of the held sum
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      a_tb[k]               = byte'(rand_range(30, 90));
      a_tb[k + HALF_A_SIZE] = byte'($urandom());
    end
    random_entries(12);
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      feat_tb[0][k] = byte'(rand_range(20, 120));
      feat_tb[6][k] = byte'(-rand_range(20, 120));
    end
    flag_tb[6] = 1'b1;
    load_run(12);
    run_nodes();
    drain_check();
    end_test("src_replace");

    // start pulsed during the run
    random_entries(10);
    load_run(10);
    pulse_start();
    repeat (3) @(negedge clk);
    check_bit("busy_o", busy_o, 1'b1);
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    wait_idle();
    drain_check();
    end_test("ignored_start");

    check_bit("overflow_o", overflow_o, 1'b0);
    random_entries(24);
    load_run(24);
    run_nodes();
    check_bit("overflow_o", overflow_o, 1'b1);
    drain_check();
    check_bit("overflow_o", overflow_o, 1'b1);
    end_test("overflow");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: wh_buffer.sv
// ===============================================
// WH entry storage and fetch sequencer; after an
// accepted start it streams entries 0..num_node-1,
// one per cycle, and holds busy until the
// coefficient pipeline has drained
// ===============================================

module wh_buffer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wh_wr_i,
  input  logic [gat_pkg::WH_ADDR_WIDTH-1:0] wh_addr_i,
  input  logic [gat_pkg::WH_WIDTH-1:0]      wh_wdata_i,
  input  logic                              start_i,
  input  logic [gat_pkg::NUM_NODE_WIDTH-1:0] num_node_i,
  output logic                              fetch_vld_o,
  output logic [gat_pkg::WH_WIDTH-1:0]      fetch_data_o,
  output logic                              busy_o
);

  import gat_pkg::*;

  logic [WH_WIDTH-1:0]        mem_q [WH_DEPTH];
  logic [WH_WIDTH-1:0]        fetch_data_q;
  logic [WH_ADDR_WIDTH-1:0]   rd_addr_q;
  logic [DRAIN_CNT_WIDTH-1:0] drain_cnt_q;
  logic                       busy_q;
  logic                       issue_q;
  logic                       fetch_vld_q;
  logic                       start_ok;
  logic                       last_addr;
  logic                       drain_done;

  // start while busy is dropped
  assign start_ok   = start_i && !busy_q;
  assign last_addr  = (NUM_NODE_WIDTH'(rd_addr_q) == num_node_i - NUM_NODE_WIDTH'(1));
  assign drain_done = !issue_q && !fetch_vld_q && (drain_cnt_q <= DRAIN_CNT_WIDTH'(1));

  // ===============================================
  // entry storage
  // ===============================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < WH_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wh_wr_i) begin
      mem_q[wh_addr_i] <= wh_wdata_i;
    end
  end

  // ===============================================
  // fetch sequencer
  // ===============================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      issue_q     <= 1'b0;
      rd_addr_q   <= '0;
      fetch_vld_q <= 1'b0;
      drain_cnt_q <= '0;
    end else begin
      fetch_vld_q <= issue_q;
      if (start_ok) begin
        busy_q    <= 1'b1;
        issue_q   <= (num_node_i != '0);
        rd_addr_q <= '0;
      end else begin
        if (issue_q) begin
          if (last_addr) begin
            issue_q <= 1'b0;
          end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
          end
        end
        if (busy_q && drain_done) begin
          busy_q <= 1'b0;
        end
      end
      // reload on every fetch, count down the pipeline latency after the last
      if (fetch_vld_q) begin
        drain_cnt_q <= DRAIN_CNT_WIDTH'(COEF_LATENCY);
      end else if (drain_cnt_q != '0) begin
        drain_cnt_q <= drain_cnt_q - 1'b1;
      end
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    if (issue_q) begin
      fetch_data_q <= mem_q[rd_addr_q];
    end
  end

  assign fetch_vld_o  = fetch_vld_q;
  assign fetch_data_o = fetch_data_q;
  assign busy_o       = busy_q;

endmodule
